// ==== icache_top.f ====
hdl/icache_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_way.sv
hdl/icache_replace.sv
hdl/icache_top.sv
testbench/axi_mem_model.sv
testbench/icache_checker.sv
testbench/tb_icache.sv

// ==== Makefile ====
TOOL       := verilator
FLAGS      := --binary --timing
LINT_FLAGS := --lint-only --timing
TOP        := tb_icache
FILELIST   := icache_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator's exit status is not trusted, the log decides
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int    CLK_PERIOD      = 10;
    localparam int    RST_CYCLES      = 4;
    localparam int    CYCLES_PER_TEST = 100;
    localparam int    SEED            = 32'h0286a6bf;
    localparam int    NAME_W          = 128;
    localparam resp_t RESP_OK         = 2'd0;
    // memory region with bit 31 set answers slave error
    localparam resp_t RESP_ERR        = 2'd2;

    logic    clk;
    logic    rst;
    addr_t   araddr;
    logic    arvalid;
    logic    arready;
    data_t   rdata;
    resp_t   rresp;
    logic    rvalid;
    logic    rready;
    axi_ar_t mem_ar;
    logic    mem_arvalid;
    logic    mem_arready;
    axi_r_t  mem_r;
    logic    mem_rvalid;
    logic    mem_rready;

    logic [NAME_W-1:0] exp_name;
    logic              exp_miss;
    resp_t             exp_resp;
    int                pass_cnt;
    int                fail_cnt;
    int                err_cnt;
    int                seed;
    logic              table_ready;

    // stimulus table, one entry per fetch
    string t_name [$];
    addr_t t_addr [$];
    logic  t_miss [$];
    resp_t t_resp [$];

    icache_top dut_i (
        .clk           (clk),
        .i_rst         (rst),
        .i_araddr      (araddr),
        .i_arvalid     (arvalid),
        .o_arready     (arready),
        .o_rdata       (rdata),
        .o_rresp       (rresp),
        .o_rvalid      (rvalid),
        .i_rready      (rready),
        .o_mem_ar      (mem_ar),
        .o_mem_arvalid (mem_arvalid),
        .i_mem_arready (mem_arready),
        .i_mem_r       (mem_r),
        .i_mem_rvalid  (mem_rvalid),
        .o_mem_rready  (mem_rready)
    );

    axi_mem_model #(.SEED(SEED)) mem_i (
        .clk       (clk),
        .i_ar      (mem_ar),
        .i_arvalid (mem_arvalid),
        .o_arready (mem_arready),
        .o_r       (mem_r),
        .o_rvalid  (mem_rvalid),
        .i_rready  (mem_rready)
    );

    icache_checker #(.NAME_W(NAME_W)) checker_i (
        .clk           (clk),
        .i_rst         (rst),
        .i_araddr      (araddr),
        .i_arvalid     (arvalid),
        .i_arready     (arready),
        .i_rdata       (rdata),
        .i_rresp       (rresp),
        .i_rvalid      (rvalid),
        .i_rready      (rready),
        .i_mem_ar      (mem_ar),
        .i_mem_arvalid (mem_arvalid),
        .i_mem_arready (mem_arready),
        .i_mem_r       (mem_r),
        .i_mem_rvalid  (mem_rvalid),
        .i_mem_rready  (mem_rready),
        .i_exp_name    (exp_name),
        .i_exp_miss    (exp_miss),
        .i_exp_resp    (exp_resp),
        .o_pass_cnt    (pass_cnt),
        .o_fail_cnt    (fail_cnt),
        .o_err_cnt     (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_test(input string name, input addr_t addr, input logic miss,
                            input resp_t resp);
        t_name.push_back(name);
        t_addr.push_back(addr);
        t_miss.push_back(miss);
        t_resp.push_back(resp);
    endtask

    // --------------------------------------------------
    // set 0 lines at 0x1000, 0x2000, 0x3000
    // --------------------------------------------------
    task automatic build_table();
        add_test("cold_miss",     32'h0000_1000, 1'b1, RESP_OK);
        add_test("hit_repeat",    32'h0000_1000, 1'b0, RESP_OK);
        add_test("hit_word1",     32'h0000_1004, 1'b0, RESP_OK);
        add_test("hit_word2",     32'h0000_1008, 1'b0, RESP_OK);
        add_test("hit_word3",     32'h0000_100c, 1'b0, RESP_OK);
        add_test("second_way",    32'h0000_2004, 1'b1, RESP_OK);
        add_test("alt_a0",        32'h0000_1008, 1'b0, RESP_OK);
        add_test("alt_b0",        32'h0000_200c, 1'b0, RESP_OK);
        add_test("alt_a1",        32'h0000_1000, 1'b0, RESP_OK);
        add_test("alt_b1",        32'h0000_2000, 1'b0, RESP_OK);
        add_test("evict_miss",    32'h0000_3008, 1'b1, RESP_OK);
        add_test("evict_refetch", 32'h0000_3008, 1'b0, RESP_OK);
        add_test("err_miss",      32'h8000_0410, 1'b1, RESP_ERR);
        add_test("err_line_hit",  32'h8000_041c, 1'b0, RESP_OK);
        add_test("set2_miss",     32'h0000_0520, 1'b1, RESP_OK);
        add_test("set2_hit",      32'h0000_0524, 1'b0, RESP_OK);
        add_test("set3_miss",     32'h0000_0530, 1'b1, RESP_OK);
        add_test("set3_hit",      32'h0000_053c, 1'b0, RESP_OK);
    endtask

    function automatic logic [NAME_W-1:0] pack_name(input string s);
        logic [NAME_W-1:0] v;
        v = '0;
        for (int i = 0; i < s.len(); i++) begin
            v = {v[NAME_W-9:0], s[i]};
        end
        return v;
    endfunction

    task automatic present(input int idx);
        araddr   = t_addr[idx];
        arvalid  = 1'b1;
        exp_name = pack_name(t_name[idx]);
        exp_miss = t_miss[idx];
        exp_resp = t_resp[idx];
    endtask

    // called and returns on a falling edge
    task automatic run_test(input int idx);
        int delay;
        present(idx);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            // next fetch offered early, must wait for this response
            if (idx + 1 < t_addr.size()) begin
                present(idx + 1);
            end
            @(negedge clk);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        exp_name    = '0;
        exp_miss    = 1'b0;
        exp_resp    = RESP_OK;
        seed        = SEED;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < t_addr.size(); i++) begin
            run_test(i);
        end
        @(negedge clk);
        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 t_addr.size(), pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == t_addr.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        repeat (RST_CYCLES + t_addr.size() * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog: the fetches did not complete within %0d cycles, the DUT hung",
                 t_addr.size() * CYCLES_PER_TEST);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/icache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_checker #(
    parameter int NAME_W = 128
) (
    input  wire logic                  clk,
    input  wire logic                  i_rst,
    // fetch side
    input  wire icache_pkg::addr_t     i_araddr,
    input  wire logic                  i_arvalid,
    input  wire logic                  i_arready,
    input  wire icache_pkg::data_t     i_rdata,
    input  wire icache_pkg::resp_t     i_rresp,
    input  wire logic                  i_rvalid,
    input  wire logic                  i_rready,
    // memory side
    input  wire icache_pkg::axi_ar_t   i_mem_ar,
    input  wire logic                  i_mem_arvalid,
    input  wire logic                  i_mem_arready,
    input  wire icache_pkg::axi_r_t    i_mem_r,
    input  wire logic                  i_mem_rvalid,
    input  wire logic                  i_mem_rready,
    // expectation for the request on offer
    input  wire logic [NAME_W-1:0]     i_exp_name,
    input  wire logic                  i_exp_miss,
    input  wire icache_pkg::resp_t     i_exp_resp,
    output int                         o_pass_cnt,
    output int                         o_fail_cnt,
    output int                         o_err_cnt
);
    import icache_pkg::*;

    // accept edge to first rvalid edge on a hit
    localparam int HIT_LATENCY = 2;

    logic [NAME_W-1:0] cur_name;
    addr_t             cur_addr;
    logic              cur_miss;
    resp_t             cur_resp;
    logic              busy;
    logic              seen_rvalid;
    logic              stalled;
    logic              refilling;
    data_t             held_data;
    resp_t             held_resp;
    int                cycle;
    int                accept_cycle;
    int                bursts;
    int                err_at_accept;

    function automatic data_t word_pattern(input addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        return {~w[31:16], w[15:0]};
    endfunction

    function automatic string name_text(input logic [NAME_W-1:0] v);
        string s;
        s = "";
        for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
            if (v[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, v[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    task automatic value_error(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("** Error: %s %s expected 0x%0h, actual 0x%0h",
                 name_text(cur_name), what, exp, act);
        o_err_cnt++;
    endtask

    task automatic plain_error(input string what);
        $display("%s: %s", name_text(cur_name), what);
        o_err_cnt++;
    endtask

    always @(posedge clk) begin
        if (i_rst) begin
            busy       = 1'b0;
            stalled    = 1'b0;
            refilling  = 1'b0;
            cycle      = 0;
            o_pass_cnt = 0;
            o_fail_cnt = 0;
            o_err_cnt  = 0;
        end else begin
            cycle++;
            // --------------------------------------------------
            // a waiting response must hold still
            // --------------------------------------------------
            if (stalled && !i_rvalid) begin
                plain_error("rvalid went low before the response was taken");
            end else if (stalled && (i_rdata != held_data || i_rresp != held_resp)) begin
                plain_error("rdata or rresp changed while rvalid waited for rready");
            end
            stalled   = i_rvalid && !i_rready;
            held_data = i_rdata;
            held_resp = i_rresp;

            if (i_arvalid && i_arready) begin
                if (busy) begin
                    plain_error("a request was accepted while a response was pending");
                end
                busy          = 1'b1;
                cur_name      = i_exp_name;
                cur_addr      = i_araddr;
                cur_miss      = i_exp_miss;
                cur_resp      = i_exp_resp;
                accept_cycle  = cycle;
                bursts        = 0;
                seen_rvalid   = 1'b0;
                err_at_accept = o_err_cnt;
            end

            // one line-aligned incrementing burst of four words
            if (i_mem_arvalid && i_mem_arready) begin
                bursts++;
                if (i_mem_ar.addr != {cur_addr[31:4], 4'h0}) begin
                    value_error("burst addr", {cur_addr[31:4], 4'h0}, i_mem_ar.addr);
                end
                if (i_mem_ar.len != 8'd3) begin
                    value_error("burst len", 32'd3, 32'(i_mem_ar.len));
                end
                if (i_mem_ar.size != 3'd2) begin
                    value_error("burst size", 32'd2, 32'(i_mem_ar.size));
                end
                if (i_mem_ar.burst != 2'd1) begin
                    value_error("burst type", 32'd1, 32'(i_mem_ar.burst));
                end
            end

            // read data ready only from address handshake to last beat
            if (i_mem_rready != refilling) begin
                value_error("memory rready", 32'(refilling), 32'(i_mem_rready));
            end
            if (i_mem_arvalid && i_mem_arready) begin
                refilling = 1'b1;
            end else if (i_mem_rvalid && i_mem_rready && i_mem_r.last) begin
                refilling = 1'b0;
            end

            if (busy && i_rvalid && !seen_rvalid) begin
                seen_rvalid = 1'b1;
                if (!cur_miss && cycle - accept_cycle != HIT_LATENCY) begin
                    value_error("hit latency", 32'(HIT_LATENCY), 32'(cycle - accept_cycle));
                end
            end

            // --------------------------------------------------
            // response taken, close the test
            // --------------------------------------------------
            if (busy && i_rvalid && i_rready) begin
                if (i_rdata != word_pattern(cur_addr)) begin
                    value_error("rdata", word_pattern(cur_addr), i_rdata);
                end
                if (i_rresp != cur_resp) begin
                    value_error("rresp", 32'(cur_resp), 32'(i_rresp));
                end
                if (bursts != (cur_miss ? 1 : 0)) begin
                    value_error("memory bursts", 32'(cur_miss ? 1 : 0), 32'(bursts));
                end
                if (o_err_cnt == err_at_accept) begin
                    $display("PASS %s", name_text(cur_name));
                    o_pass_cnt++;
                end else begin
                    $display("FAIL %s", name_text(cur_name));
                    o_fail_cnt++;
                end
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int SEED = 1
) (
    input  wire logic                  clk,
    input  wire icache_pkg::axi_ar_t   i_ar,
    input  wire logic                  i_arvalid,
    output logic                       o_arready,
    output icache_pkg::axi_r_t         o_r,
    output logic                       o_rvalid,
    input  wire logic                  i_rready
);
    import icache_pkg::*;

    localparam int    BEATS    = 4;
    // slave error for the region with bit 31 set
    localparam resp_t RESP_ERR = 2'd2;

    int    seed;
    addr_t base;
    logic  taken;

    // upper half of the word address inverted
    function automatic data_t word_pattern(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    task automatic idle_gap();
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);
    endtask

    initial begin
        seed      = SEED;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
        forever begin
            @(negedge clk);
            if (i_arvalid) begin
                // late address ready
                idle_gap();
                base      = i_ar.addr;
                o_arready = 1'b1;
                @(negedge clk);
                o_arready = 1'b0;
                for (int b = 0; b < BEATS; b++) begin
                    idle_gap();
                    o_r.data = word_pattern(base + addr_t'(4 * b));
                    o_r.last = (b == BEATS - 1);
                    o_r.resp = (o_r.last && base[31]) ? RESP_ERR : 2'd0;
                    o_rvalid = 1'b1;
                    // rready only changes at the rising edge
                    do begin
                        taken = i_rready;
                        @(negedge clk);
                    end while (!taken);
                    o_rvalid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic                  clk,
    input  wire logic                  i_rst,
    // fetch side
    input  wire icache_pkg::addr_t     i_araddr,
    input  wire logic                  i_arvalid,
    output logic                       o_arready,
    output icache_pkg::data_t          o_rdata,
    output icache_pkg::resp_t          o_rresp,
    output logic                       o_rvalid,
    input  wire logic                  i_rready,
    // memory side
    output icache_pkg::axi_ar_t        o_mem_ar,
    output logic                       o_mem_arvalid,
    input  wire logic                  i_mem_arready,
    input  wire icache_pkg::axi_r_t    i_mem_r,
    input  wire logic                  i_mem_rvalid,
    output logic                       o_mem_rready
);
    import icache_pkg::*;

    addr_t     req_addr;
    logic      hit_any;
    logic      refill_start;
    logic      beat_we;
    word_sel_t beat_sel;
    data_t     beat_data;
    logic      tag_we;
    way_mask_t way_hit;
    way_mask_t way_valid;
    way_mask_t victim;
    data_t     way_rdata [WAY_NUM];

    // --------------------------------------------------
    // controller
    // --------------------------------------------------
    icache_ctrl ctrl_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_araddr       (i_araddr),
        .i_arvalid      (i_arvalid),
        .o_arready      (o_arready),
        .o_rvalid       (o_rvalid),
        .o_rresp        (o_rresp),
        .i_rready       (i_rready),
        .i_hit          (hit_any),
        .o_req_addr     (req_addr),
        .o_refill_start (refill_start),
        .o_beat_we      (beat_we),
        .o_beat_sel     (beat_sel),
        .o_beat_data    (beat_data),
        .o_tag_we       (tag_we),
        .o_mem_ar       (o_mem_ar),
        .o_mem_arvalid  (o_mem_arvalid),
        .i_mem_arready  (i_mem_arready),
        .i_mem_r        (i_mem_r),
        .i_mem_rvalid   (i_mem_rvalid),
        .o_mem_rready   (o_mem_rready)
    );

    // --------------------------------------------------
    // ways
    // --------------------------------------------------
    for (genvar g = 0; g < WAY_NUM; g++) begin : gen_way
        icache_way way_i (
            .clk         (clk),
            .i_rst       (i_rst),
            .i_addr      (req_addr),
            .i_fill_sel  (victim[g]),
            .i_beat_we   (beat_we),
            .i_beat_sel  (beat_sel),
            .i_beat_data (beat_data),
            .i_tag_we    (tag_we),
            .o_valid     (way_valid[g]),
            .o_hit       (way_hit[g]),
            .o_rdata     (way_rdata[g])
        );
    end

    icache_replace replace_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_set_valid    (way_valid),
        .i_refill_start (refill_start),
        .o_victim       (victim)
    );

    assign hit_any = |way_hit;

    // at most one way hits, so an and-or mux is enough
    always_comb begin
        o_rdata = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            o_rdata = o_rdata | (way_rdata[w] & {DATA_W{way_hit[w]}});
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_replace.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_replace (
    input  wire logic                  clk,
    input  wire logic                  i_rst,
    input  wire icache_pkg::way_mask_t i_set_valid,
    input  wire logic                  i_refill_start,
    output icache_pkg::way_mask_t      o_victim
);
    import icache_pkg::*;

    logic [7:0] lfsr_q;
    way_mask_t  free_mask;
    way_mask_t  rand_mask;
    way_mask_t  victim_q;
    logic       found;

    // free-running galois lfsr
    always_ff @(posedge clk) begin
        if (i_rst) begin
            lfsr_q <= 8'd1;
        end else begin
            lfsr_q <= {lfsr_q[6], lfsr_q[5] ^ lfsr_q[7], lfsr_q[4] ^ lfsr_q[7],
                       lfsr_q[3] ^ lfsr_q[7], lfsr_q[2:0], lfsr_q[7]};
        end
    end

    // lowest way with a clear valid bit
    always_comb begin
        free_mask = '0;
        found     = 1'b0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (!i_set_valid[w] && !found) begin
                free_mask[w] = 1'b1;
                found        = 1'b1;
            end
        end
    end

    assign rand_mask = way_mask_t'(1) << lfsr_q[0];

    // held until the next refill
    always_ff @(posedge clk) begin
        if (i_rst) begin
            victim_q <= '0;
        end else if (i_refill_start) begin
            victim_q <= found ? free_mask : rand_mask;
        end
    end

    assign o_victim = victim_q;

endmodule

`default_nettype wire

// ==== hdl/icache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_way (
    input  wire logic                  clk,
    input  wire logic                  i_rst,
    input  wire icache_pkg::addr_t     i_addr,
    // this way is the refill victim
    input  wire logic                  i_fill_sel,
    input  wire logic                  i_beat_we,
    input  wire icache_pkg::word_sel_t i_beat_sel,
    input  wire icache_pkg::data_t     i_beat_data,
    input  wire logic                  i_tag_we,
    output logic                       o_valid,
    output logic                       o_hit,
    output icache_pkg::data_t          o_rdata
);
    import icache_pkg::*;

    logic [SET_NUM-1:0] valid_q;
    tag_t               tag_mem [SET_NUM];
    data_t              data_mem [SET_NUM*WORDS_PER_LINE];
    data_t              rdata_q;

    tag_t      addr_tag;
    index_t    addr_index;
    word_sel_t addr_word;

    logic [INDEX_W+WORD_SEL_W-1:0] rd_ptr;
    logic [INDEX_W+WORD_SEL_W-1:0] wr_ptr;

    // address fields, low two bits ignored
    assign addr_tag   = i_addr[ADDR_W-1 -: TAG_W];
    assign addr_index = i_addr[LINE_OFFSET_W +: INDEX_W];
    assign addr_word  = i_addr[LINE_OFFSET_W-1 -: WORD_SEL_W];

    assign rd_ptr = {addr_index, addr_word};
    assign wr_ptr = {addr_index, i_beat_sel};

    // --------------------------------------------------
    // valid bits and tags
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= '0;
        end else if (i_tag_we && i_fill_sel) begin
            valid_q[addr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_tag_we && i_fill_sel) begin
            tag_mem[addr_index] <= addr_tag;
        end
    end

    // word array, read registered every cycle
    always_ff @(posedge clk) begin
        if (i_beat_we && i_fill_sel) begin
            data_mem[wr_ptr] <= i_beat_data;
        end
        rdata_q <= data_mem[rd_ptr];
    end

    assign o_valid = valid_q[addr_index];
    assign o_hit   = o_valid && (tag_mem[addr_index] == addr_tag);
    assign o_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire logic                  clk,
    input  wire logic                  i_rst,
    // fetch side
    input  wire icache_pkg::addr_t     i_araddr,
    input  wire logic                  i_arvalid,
    output logic                       o_arready,
    output logic                       o_rvalid,
    output icache_pkg::resp_t          o_rresp,
    input  wire logic                  i_rready,
    // lookup result from the ways
    input  wire logic                  i_hit,
    // to ways and replacement
    output icache_pkg::addr_t          o_req_addr,
    output logic                       o_refill_start,
    output logic                       o_beat_we,
    output icache_pkg::word_sel_t      o_beat_sel,
    output icache_pkg::data_t          o_beat_data,
    output logic                       o_tag_we,
    // memory side
    output icache_pkg::axi_ar_t        o_mem_ar,
    output logic                       o_mem_arvalid,
    input  wire logic                  i_mem_arready,
    input  wire icache_pkg::axi_r_t    i_mem_r,
    input  wire logic                  i_mem_rvalid,
    output logic                       o_mem_rready
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM_ADDR,
        ST_MEM_DATA,
        ST_RESPOND
    } state_t;

    state_t    state_q;
    state_t    state_d;
    addr_t     req_addr_q;
    resp_t     resp_q;
    word_sel_t beat_cnt_q;

    logic req_accept;
    logic ar_done;
    logic beat_take;
    logic last_beat;

    // --------------------------------------------------
    // handshakes
    // --------------------------------------------------
    assign req_accept = i_arvalid & o_arready;
    assign ar_done    = o_mem_arvalid & i_mem_arready;
    assign beat_take  = i_mem_rvalid & o_mem_rready;
    assign last_beat  = beat_take & i_mem_r.last;

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (req_accept) state_d = ST_LOOKUP;
            ST_LOOKUP:   state_d = i_hit ? ST_RESPOND : ST_MEM_ADDR;
            ST_MEM_ADDR: if (ar_done) state_d = ST_MEM_DATA;
            // back to lookup, which then hits
            ST_MEM_DATA: if (last_beat) state_d = ST_LOOKUP;
            ST_RESPOND:  if (i_rready) state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    // request address, latched on accept
    always_ff @(posedge clk) begin
        if (req_accept) begin
            req_addr_q <= i_araddr;
        end
    end

    // response code and refill beat counter
    always_ff @(posedge clk) begin
        if (i_rst) begin
            resp_q     <= RESP_OKAY;
            beat_cnt_q <= '0;
        end else begin
            if (req_accept) begin
                resp_q <= RESP_OKAY;
            end else if (last_beat) begin
                resp_q <= i_mem_r.resp;
            end
            if (ar_done) begin
                beat_cnt_q <= '0;
            end else if (beat_take) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign o_arready      = (state_q == ST_IDLE);
    assign o_rvalid       = (state_q == ST_RESPOND);
    assign o_rresp        = resp_q;
    assign o_req_addr     = req_addr_q;
    assign o_refill_start = (state_q == ST_LOOKUP) & ~i_hit;

    // one word per beat, tag and valid on the last one
    assign o_beat_we   = beat_take;
    assign o_beat_sel  = beat_cnt_q;
    assign o_beat_data = i_mem_r.data;
    assign o_tag_we    = last_beat;

    // line-aligned burst request
    always_comb begin
        o_mem_ar.addr  = {req_addr_q[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
        o_mem_ar.len   = AR_LEN;
        o_mem_ar.size  = AR_SIZE;
        o_mem_ar.burst = AR_BURST;
    end

    assign o_mem_arvalid = (state_q == ST_MEM_ADDR);
    assign o_mem_rready  = (state_q == ST_MEM_DATA);

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // --------------------------------------------------
    // cache geometry
    // --------------------------------------------------
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int WAY_NUM        = 2;
    localparam int SET_NUM        = 4;
    localparam int INDEX_W        = 2;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_W     = 2;
    // byte offset inside a line
    localparam int LINE_OFFSET_W  = 4;
    localparam int TAG_W          = ADDR_W - INDEX_W - LINE_OFFSET_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [WAY_NUM-1:0]    way_mask_t;
    typedef logic [1:0]            resp_t;

    // --------------------------------------------------
    // burst read constants
    // --------------------------------------------------
    localparam logic [7:0] AR_LEN    = 8'(WORDS_PER_LINE - 1);
    // four bytes per beat
    localparam logic [2:0] AR_SIZE   = 3'b010;
    // incrementing burst
    localparam logic [1:0] AR_BURST  = 2'b01;
    localparam resp_t      RESP_OKAY = 2'b00;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

endpackage

`default_nettype wire
